//--- mlsdDetector.f
src/mlsdPkg.sv
src/delayBuffer.sv
src/flatBuffer.sv
src/potentialCodesGen.sv
src/mlsdDecision.sv
src/mlsdDetector.sv
testbench/mlsdDetector_asserts.sv
testbench/mlsdDetectorTb.sv

//--- runSim.sh
#!/bin/bash
# Compile and run the MLSD detector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mlsdDetectorTb -Mdir obj_dir -f mlsdDetector.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

simOutput=$(./obj_dir/VmlsdDetectorTb)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" <<< "$simOutput"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/mlsdDetectorTb.sv
`timescale 1ns/10ps

module mlsdDetectorTb;
	import mlsdPkg::*;

	localparam int rowWords   = 12;
	localparam int totalWords = rowWords + 4; // Extra words flush the pipeline
	localparam int numSamples = totalWords * numChannels;
	localparam int numRows    = 10;
	localparam int timeoutNs  = 100000;

	localparam int patRandom = 0;
	localparam int patOnes   = 1;
	localparam int patZeros  = 2;
	localparam int patAlt    = 3;
	localparam int patMixed  = 4; // Kind changes every word

	// Columns are tap0, tap1, tap2, pattern kind, noise amplitude
	int stimTable [numRows][5] = '{
		'{2, 1, 1, patRandom, 0},
		'{2, 1, 1, patOnes, 0},
		'{2, 1, 1, patZeros, 0},
		'{2, 1, 1, patAlt, 0},
		'{90, 50, 30, patOnes, 0}, // Saturates high
		'{90, 50, 30, patZeros, 0}, // Saturates low
		'{20, 8, -6, patRandom, 12},
		'{10, 4, 2, patRandom, 30}, // Noise large enough to flip bits
		'{0, 0, 0, patRandom, 5}, // Energies always tie
		'{2, 1, 1, patMixed, 0}
	};

	logic  clk;
	logic  rst;
	code_t codes       [numChannels];
	bit_t  bits        [numChannels];
	tap_t  channelEst  [estDepth];
	bit_t  predictBits [numChannels];

	int sentBits [numSamples];
	int rxCodes  [numSamples];
	int taps     [estDepth];
	int errorCount;
	int checkCount;

	mlsdDetector dut_i (
		.clk        (clk),
		.rst        (rst),
		.codes      (codes),
		.bits       (bits),
		.channelEst (channelEst),
		.predictBits(predictBits)
	);

	always #4 clk = ~clk;

	function automatic int clampCode(input int value);
		return (value > codeMax) ? codeMax : ((value < codeMin) ? codeMin : value);
	endfunction

	function automatic int bitAt(input int g);
		return (g < 0) ? 0 : sentBits[g]; // History before the stream is reset zeros
	endfunction

	function automatic int symbolAt(input int g);
		return (bitAt(g) != 0) ? 1 : -1;
	endfunction

	function automatic int codeAt(input int g);
		return (g < 0) ? 0 : rxCodes[g];
	endfunction

	// Channel output at sample g; a nonzero hyp replaces the symbol at pos
	function automatic int channelOut(input int g, input int pos, input int hyp);
		int sum;
		int sym;
		sum = 0;
		for (int j = 0; j < estDepth; j++) begin
			sym = (g - j == pos && hyp != 0) ? hyp : symbolAt(g - j);
			sum += taps[j] * sym;
		end
		return clampCode(sum);
	endfunction

	function automatic logic [numChannels-1:0] modelDecision(input int word);
		logic [numChannels-1:0] result;
		int energy [2];
		int pos;
		int diff;
		for (int c = 0; c < numChannels; c++) begin
			pos = word * numChannels + c;
			for (int h = 0; h < 2; h++) begin
				energy[h] = 0;
				for (int k = 0; k < seqLength; k++) begin
					diff = codeAt(pos + k) - channelOut(pos + k, pos, 2 * h - 1);
					energy[h] += diff * diff;
				end
			end
			result[c] = (energy[1] < energy[0]); // Ties decide 0
		end
		return result;
	endfunction

	function automatic logic [numChannels-1:0] packBits();
		logic [numChannels-1:0] outBits;
		for (int c = 0; c < numChannels; c++) begin
			outBits[c] = predictBits[c];
		end
		return outBits;
	endfunction

	function automatic int noiseSample(input int amp);
		return int'($urandom % (2 * amp + 1)) - amp;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic waitCycles(input int count);
		for (int n = 0; n < count; n++) begin
			@(posedge clk);
		end
		#1; // Drive delay after the edge
	endtask

	task automatic buildRow(input int row);
		int kind;
		int g;
		for (int w = 0; w < totalWords; w++) begin
			kind = (stimTable[row][3] == patMixed) ? w % 4 : stimTable[row][3];
			for (int c = 0; c < numChannels; c++) begin
				g = w * numChannels + c;
				case (kind)
					patOnes:  sentBits[g] = 1;
					patZeros: sentBits[g] = 0;
					patAlt:   sentBits[g] = g % 2; // Alternates across channel boundaries
					default:  sentBits[g] = int'($urandom % 2);
				endcase
			end
		end
		for (int s = 0; s < numSamples; s++) begin
			rxCodes[s] = clampCode(channelOut(s, s, 0) + noiseSample(stimTable[row][4]));
		end
	endtask

	task automatic resetDut();
		rst = 1'b1;
		for (int j = 0; j < estDepth; j++) begin
			channelEst[j] = tap_t'(taps[j]);
		end
		for (int c = 0; c < numChannels; c++) begin
			codes[c] = '0;
			bits[c] = 1'b0;
		end
		waitCycles(5);
		rst = 1'b0;
	endtask

	task automatic runRow(input int row);
		logic [numChannels-1:0] expected;
		logic [numChannels-1:0] sent;
		int word;
		for (int j = 0; j < estDepth; j++) begin
			taps[j] = stimTable[row][j];
		end
		buildRow(row);
		resetDut();
		for (int i = 0; i < totalWords; i++) begin
			word = i - 4; // Word whose decisions leave the pipeline now
			expected = (word < -2) ? '0 : modelDecision(word);
			compareValue($sformatf("predictBits (row %0d word %0d)", row, word),
				packBits(), expected);
			if (word >= 0 && stimTable[row][4] == 0 && taps[0] != 0) begin
				for (int c = 0; c < numChannels; c++) begin
					sent[c] = (sentBits[word * numChannels + c] != 0);
				end
				compareValue($sformatf("predictBits vs sent (row %0d word %0d)", row, word),
					packBits(), sent);
			end
			for (int c = 0; c < numChannels; c++) begin
				codes[c] = code_t'(rxCodes[i * numChannels + c]);
				bits[c] = (sentBits[i * numChannels + c] != 0);
			end
			waitCycles(1);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		for (int c = 0; c < numChannels; c++) begin
			codes[c] = '0;
			bits[c] = 1'b0;
		end
		for (int j = 0; j < estDepth; j++) begin
			channelEst[j] = '0;
		end
		errorCount = 0;
		checkCount = 0;
		void'($urandom(32'h09df3011));
		for (int row = 0; row < numRows; row++) begin
			runRow(row);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(timeoutNs);
		$display("Timeout: the stimulus did not finish in %0d ns", timeoutNs);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- testbench/mlsdDetector_asserts.sv
`timescale 1ns/10ps

module mlsdDetector_asserts (
	input logic          clk,
	input logic          rst,
	input mlsdPkg::bit_t predictBits [mlsdPkg::numChannels]
);
	import mlsdPkg::*;

	logic [numChannels-1:0] bitsPacked;

	always_comb begin
		for (int c = 0; c < numChannels; c++) begin
			bitsPacked[c] = predictBits[c];
		end
	end

	resetClears: assert property (@(posedge clk) rst |=> bitsPacked == '0)
		else $error("predictBits not zero in the cycle after reset");

	noUnknownOut: assert property (@(posedge clk) disable iff (rst) !$isunknown(bitsPacked))
		else $error("predictBits holds unknown bits after reset");

endmodule

bind mlsdDetector mlsdDetector_asserts asserts_i (
	.clk        (clk),
	.rst        (rst),
	.predictBits(predictBits)
);

//--- src/mlsdDetector.sv
`timescale 1ns/10ps

module mlsdDetector (
	input  logic           clk,
	input  logic           rst,
	input  mlsdPkg::code_t codes       [mlsdPkg::numChannels],
	input  mlsdPkg::bit_t  bits        [mlsdPkg::numChannels],
	input  mlsdPkg::tap_t  channelEst  [mlsdPkg::estDepth],
	output mlsdPkg::bit_t  predictBits [mlsdPkg::numChannels]
);
	import mlsdPkg::*;

	code_t delayedCodes [numChannels];
	code_t flatCodes    [flatLength];
	bit_t  flatBits     [flatLength];
	code_t estSeq       [2][numChannels][seqLength];

	// Codes lag one cycle so they reach the center slot with the registered hypotheses
	delayBuffer #(
		.depth(1)
	) codeDelay_i (
		.clk(clk),
		.rst(rst),
		.in (codes),
		.out(delayedCodes)
	);

	flatBuffer #(
		.payload_t(code_t)
	) codeHistory_i (
		.clk    (clk),
		.rst    (rst),
		.in     (delayedCodes),
		.flatOut(flatCodes)
	);

	flatBuffer #(
		.payload_t(bit_t)
	) bitHistory_i (
		.clk    (clk),
		.rst    (rst),
		.in     (bits),
		.flatOut(flatBits)
	);

	potentialCodesGen codeGen_i (
		.clk       (clk),
		.rst       (rst),
		.flatBits  (flatBits),
		.channelEst(channelEst),
		.estSeq    (estSeq)
	);

	mlsdDecision decision_i (
		.clk        (clk),
		.rst        (rst),
		.flatCodes  (flatCodes),
		.estSeq     (estSeq),
		.predictBits(predictBits)
	);

endmodule

//--- src/mlsdDecision.sv
`timescale 1ns/10ps

module mlsdDecision (
	input  logic           clk,
	input  logic           rst,
	input  mlsdPkg::code_t flatCodes   [mlsdPkg::flatLength],
	input  mlsdPkg::code_t estSeq      [2][mlsdPkg::numChannels][mlsdPkg::seqLength],
	output mlsdPkg::bit_t  predictBits [mlsdPkg::numChannels]
);
	import mlsdPkg::*;

	energy_t errEnergy [2][numChannels]; // [hypothesis][channel]

	// One extra bit keeps the difference of two codes exact
	function automatic energy_t squaredError(input code_t received, input code_t expected);
		logic signed [codeBitwidth:0] diff;
		logic signed [2*codeBitwidth+1:0] square;
		diff = received - expected;
		square = diff * diff;
		return energy_t'(square);
	endfunction

	always_comb begin
		int base;
		for (int c = 0; c < numChannels; c++) begin
			base = centerBuffer * numChannels + c;
			for (int h = 0; h < 2; h++) begin
				errEnergy[h][c] = '0;
				// Received window starts at the sample under decision
				for (int k = 0; k < seqLength; k++) begin
					errEnergy[h][c] = errEnergy[h][c]
						+ squaredError(flatCodes[base + k], estSeq[h][c][k]);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			foreach (predictBits[c]) begin
				predictBits[c] <= 1'b0;
			end
		end else begin
			for (int c = 0; c < numChannels; c++) begin
				predictBits[c] <= (errEnergy[1][c] < errEnergy[0][c]); // Tie goes to 0
			end
		end
	end

endmodule

//--- src/potentialCodesGen.sv
`timescale 1ns/10ps

module potentialCodesGen (
	input  logic           clk,
	input  logic           rst,
	input  mlsdPkg::bit_t  flatBits   [mlsdPkg::flatLength],
	input  mlsdPkg::tap_t  channelEst [mlsdPkg::estDepth],
	output mlsdPkg::code_t estSeq     [2][mlsdPkg::numChannels][mlsdPkg::seqLength]
);
	import mlsdPkg::*;

	code_t nextSeq [2][numChannels][seqLength];

	// Tap times a +1/-1 symbol
	function automatic acc_t tapTerm(input tap_t tap, input bit_t symbolBit);
		acc_t ext;
		ext = acc_t'(tap);
		return symbolBit ? ext : -ext;
	endfunction

	// Clamp the convolution sum into the code range
	function automatic code_t saturate(input acc_t value);
		code_t result;
		if (value > codeMax) begin
			result = code_t'(codeMax);
		end else if (value < codeMin) begin
			result = code_t'(codeMin);
		end else begin
			result = code_t'(value);
		end
		return result;
	endfunction

	always_comb begin
		int idx;
		int src;
		acc_t acc;
		bit_t symbolBit;
		for (int h = 0; h < 2; h++) begin
			for (int c = 0; c < numChannels; c++) begin
				for (int k = 0; k < seqLength; k++) begin
					idx = centerBuffer * numChannels + c + k;
					acc = '0;
					for (int j = 0; j < estDepth; j++) begin
						src = idx - j;
						symbolBit = 1'b0;
						// Taps reaching outside the window add nothing
						if (src >= 0 && src < flatLength) begin
							if (src == centerBuffer * numChannels + c) begin
								symbolBit = h[0]; // Position under decision
							end else begin
								symbolBit = flatBits[src];
							end
							acc = acc + tapTerm(channelEst[j], symbolBit);
						end
					end
					nextSeq[h][c][k] = saturate(acc);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			foreach (estSeq[h, c, k]) begin
				estSeq[h][c][k] <= '0;
			end
		end else begin
			estSeq <= nextSeq;
		end
	end

endmodule

//--- src/flatBuffer.sv
`timescale 1ns/10ps

module flatBuffer #(
	parameter type payload_t = mlsdPkg::bit_t
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t in      [mlsdPkg::numChannels],
	output payload_t flatOut [mlsdPkg::flatLength]
);
	import mlsdPkg::*;

	// Slot 0 is the oldest word, slot bufferDepth-1 the newest
	payload_t words [bufferDepth][numChannels];

	always_ff @(posedge clk) begin
		if (rst) begin
			foreach (words[s, c]) begin
				words[s][c] <= '0;
			end
		end else begin
			for (int s = 0; s < bufferDepth - 1; s++) begin
				words[s] <= words[s + 1];
			end
			words[bufferDepth - 1] <= in;
		end
	end

	// Flat index is slot * numChannels + channel, so index order is time order
	always_comb begin
		for (int s = 0; s < bufferDepth; s++) begin
			for (int c = 0; c < numChannels; c++) begin
				flatOut[s * numChannels + c] = words[s][c];
			end
		end
	end

endmodule

//--- src/delayBuffer.sv
`timescale 1ns/10ps

module delayBuffer #(
	parameter int depth = 1
) (
	input  logic           clk,
	input  logic           rst,
	input  mlsdPkg::code_t in  [mlsdPkg::numChannels],
	output mlsdPkg::code_t out [mlsdPkg::numChannels]
);
	import mlsdPkg::*;

	code_t stages [depth][numChannels]; // stages[0] holds the newest word

	always_ff @(posedge clk) begin
		if (rst) begin
			foreach (stages[d, c]) begin
				stages[d][c] <= '0;
			end
		end else begin
			stages[0] <= in;
			for (int d = 1; d < depth; d++) begin
				stages[d] <= stages[d - 1];
			end
		end
	end

	// Oldest stage leaves the chain
	assign out = stages[depth - 1];

endmodule

//--- src/mlsdPkg.sv
package mlsdPkg;

	localparam int numChannels  = 4; // Samples per word
	localparam int codeBitwidth = 8;
	localparam int estBitwidth  = 8;
	localparam int estDepth     = 3; // Channel taps
	localparam int seqLength    = 3; // Samples compared per hypothesis

	// Whole words of history needed around the word under decision
	localparam int numPastBuffers   = (estDepth - 1 + numChannels - 1) / numChannels;
	localparam int numFutureBuffers = (seqLength - 1 + numChannels - 1) / numChannels;

	localparam int bufferDepth  = numPastBuffers + numFutureBuffers + 1;
	localparam int centerBuffer = numPastBuffers;
	localparam int flatLength   = numChannels * bufferDepth;

	// Squared difference of two codes, summed over the sequence
	localparam int energyBitwidth = 2 * (codeBitwidth + 1) + $clog2(seqLength);

	// Convolution sum before saturation
	localparam int accBitwidth = estBitwidth + $clog2(estDepth) + 1;

	localparam int codeMax = 2 ** (codeBitwidth - 1) - 1;
	localparam int codeMin = -(2 ** (codeBitwidth - 1));

	typedef logic signed [codeBitwidth-1:0] code_t;
	typedef logic bit_t; // 1 is symbol +1, 0 is symbol -1
	typedef logic signed [estBitwidth-1:0] tap_t;
	typedef logic [energyBitwidth-1:0] energy_t;
	typedef logic signed [accBitwidth-1:0] acc_t;

endpackage
